// ==== design/cp0_reg_pkg.sv ====
package cp0_reg_pkg;

	// register numbers, cp0_addr[7:3]
	localparam logic [4:0] badvaddr_num = 5'd8;
	localparam logic [4:0] count_num    = 5'd9;
	localparam logic [4:0] compare_num  = 5'd11;
	localparam logic [4:0] status_num   = 5'd12;
	localparam logic [4:0] cause_num    = 5'd13;
	localparam logic [4:0] epc_num      = 5'd14;

	// only select 0 exists, cp0_addr[2:0]
	localparam logic [2:0] cp0_sel0 = 3'd0;

	// status fields
	localparam int status_ie_bit  = 0;
	localparam int status_exl_bit = 1;
	localparam int status_im_lsb  = 8;
	localparam int status_bev_bit = 22;

	// cause fields
	localparam int cause_exccode_lsb = 2;
	localparam int cause_ip_lsb      = 8;
	localparam int cause_ti_bit      = 30;
	localparam int cause_bd_bit      = 31;

	// widths of the multi-bit fields
	localparam int status_im_w    = 8;
	localparam int cause_ip_w     = 8;
	localparam int cause_exccode_w = 5;

	// software interrupt bits in cause.ip
	localparam int cause_ip_sw_w = 2;

endpackage

// ==== design/exc_pkg.sv ====
package exc_pkg;

	// one-hot exc_type width
	localparam int exc_n = 7;

	// bit position of each kind in exc_type
	typedef enum int {
		exc_ov   = 0,
		exc_ri   = 1,
		exc_bp   = 2,
		exc_sys  = 3,
		exc_ades = 4,
		exc_adel = 5,
		exc_int  = 6
	} exc_kind_e;

	// cause.exccode values
	localparam logic [4:0] exccode_int  = 5'h00;
	localparam logic [4:0] exccode_adel = 5'h04;
	localparam logic [4:0] exccode_ades = 5'h05;
	localparam logic [4:0] exccode_sys  = 5'h08;
	localparam logic [4:0] exccode_bp   = 5'h09;
	localparam logic [4:0] exccode_ri   = 5'h0a;
	localparam logic [4:0] exccode_ov   = 5'h0c;

	// general exception entry with bev set
	localparam logic [31:0] exc_vector_default = 32'hbfc0_0380;

endpackage

// ==== design/exc_prioritizer.sv ====
module exc_prioritizer (
	input  logic                      commit_valid,
	input  logic [31:0]               commit_pc,
	input  logic                      fetch_adel,
	input  logic                      ri,
	input  logic                      ov,
	input  logic                      sys,
	input  logic                      bp,
	input  logic                      mem_adel,
	input  logic                      mem_ades,
	input  logic [31:0]               mem_vaddr,
	input  logic                      cp0_wen,
	input  logic                      eret,
	input  logic                      int_pending,
	output logic [exc_pkg::exc_n-1:0] exc_type,
	output logic                      exc_take,
	output logic [31:0]               bad_vaddr,
	output logic                      cp0_we_q,
	output logic                      eret_q
);
	import exc_pkg::*;

	exc_kind_e kind;
	logic      hit;

	// highest priority flag wins
	always_comb begin
		kind = exc_int;
		hit = 1'b1;
		bad_vaddr = commit_pc;
		if (int_pending) begin
			kind = exc_int;
		end else if (fetch_adel) begin
			kind = exc_adel;
		end else if (ri) begin
			kind = exc_ri;
		end else if (ov) begin
			kind = exc_ov;
		end else if (sys) begin
			kind = exc_sys;
		end else if (bp) begin
			kind = exc_bp;
		end else if (mem_adel) begin
			kind = exc_adel;
			bad_vaddr = mem_vaddr;
		end else if (mem_ades) begin
			kind = exc_ades;
			bad_vaddr = mem_vaddr;
		end else begin
			hit = 1'b0;
		end
	end

	// nothing is taken without a committing instruction
	assign exc_type = (commit_valid && hit) ? exc_n'(1) << kind : '0;
	assign exc_take = |exc_type;

	// an exception kills the mtc0 and the eret
	assign cp0_we_q = commit_valid && cp0_wen && !exc_take;
	assign eret_q   = commit_valid && eret && !exc_take;

endmodule

// ==== design/cp0_regs.sv ====
module cp0_regs (
	input  logic                      clk,
	input  logic                      rst,
	input  logic [7:0]                cp0_addr,
	input  logic                      cp0_we_q,
	input  logic [31:0]               cp0_wdata,
	output logic [31:0]               cp0_rdata,
	input  logic [exc_pkg::exc_n-1:0] exc_type,
	input  logic [31:0]               commit_pc,
	input  logic                      commit_is_slot,
	input  logic [31:0]               bad_vaddr,
	input  logic [5:0]                ext_int,
	input  logic                      eret_q,
	output logic [31:0]               epc,
	output logic                      int_pending
);
	import cp0_reg_pkg::*;
	import exc_pkg::*;

	logic [4:0]  reg_num;
	logic        sel_ok;
	logic        wr_count;
	logic        wr_compare;
	logic        wr_status;
	logic        wr_cause;
	logic        wr_epc;

	logic        exc_any;
	logic        exc_addr;
	logic        exc_first;
	logic [4:0]  exc_code;

	logic [31:0] badvaddr;
	logic [31:0] count;
	logic [31:0] compare;
	logic        tick;
	logic [7:0]  status_im;
	logic        status_exl;
	logic        status_ie;
	logic        cause_bd;
	logic        cause_ti;
	logic [7:0]  cause_ip;
	logic [4:0]  cause_exccode;
	logic [31:0] status_r;
	logic [31:0] cause_r;

	assign reg_num = cp0_addr[7:3];
	assign sel_ok  = cp0_addr[2:0] == cp0_sel0;

	assign wr_count   = cp0_we_q && sel_ok && reg_num == count_num;
	assign wr_compare = cp0_we_q && sel_ok && reg_num == compare_num;
	assign wr_status  = cp0_we_q && sel_ok && reg_num == status_num;
	assign wr_cause   = cp0_we_q && sel_ok && reg_num == cause_num;
	assign wr_epc     = cp0_we_q && sel_ok && reg_num == epc_num;

	assign exc_any  = |exc_type;
	assign exc_addr = exc_type[exc_adel] || exc_type[exc_ades];
	// epc and bd only on the outermost exception
	assign exc_first = exc_any && !status_exl;

	// exc_type is one-hot so the terms never overlap
	assign exc_code = ({5{exc_type[exc_int]}}  & exccode_int)
	                | ({5{exc_type[exc_adel]}} & exccode_adel)
	                | ({5{exc_type[exc_ades]}} & exccode_ades)
	                | ({5{exc_type[exc_sys]}}  & exccode_sys)
	                | ({5{exc_type[exc_bp]}}   & exccode_bp)
	                | ({5{exc_type[exc_ri]}}   & exccode_ri)
	                | ({5{exc_type[exc_ov]}}   & exccode_ov);

	always_ff @(posedge clk) begin
		if (rst) begin
			status_ie <= 1'b0;
			status_im <= '0;
		end else if (wr_status) begin
			status_ie <= cp0_wdata[status_ie_bit];
			status_im <= cp0_wdata[status_im_lsb +: status_im_w];
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			status_exl <= 1'b0;
		else if (exc_any)
			status_exl <= 1'b1;
		else if (eret_q)
			status_exl <= 1'b0;
		else if (wr_status)
			status_exl <= cp0_wdata[status_exl_bit];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cause_bd <= 1'b0;
			cause_exccode <= '0;
		end else if (exc_any) begin
			cause_exccode <= exc_code;
			if (exc_first)
				cause_bd <= commit_is_slot;
		end
	end

	// compare write wins over a match in the same cycle
	always_ff @(posedge clk) begin
		if (rst)
			cause_ti <= 1'b0;
		else if (wr_compare)
			cause_ti <= 1'b0;
		else if (count == compare)
			cause_ti <= 1'b1;
	end

	// hardware lines, timer shares ip7
	always_ff @(posedge clk) begin
		if (rst)
			cause_ip[7:2] <= '0;
		else
			cause_ip[7:2] <= {ext_int[5] | cause_ti, ext_int[4:0]};
	end

	always_ff @(posedge clk) begin
		if (rst)
			cause_ip[1:0] <= '0;
		else if (wr_cause)
			cause_ip[1:0] <= cp0_wdata[cause_ip_lsb +: cause_ip_sw_w];
	end

	always_ff @(posedge clk) begin
		if (exc_first)
			epc <= commit_is_slot ? commit_pc - 32'd4 : commit_pc;
		else if (wr_epc)
			epc <= cp0_wdata;
	end

	always_ff @(posedge clk) begin
		if (exc_addr)
			badvaddr <= bad_vaddr;
	end

	// count runs at half the core clock
	always_ff @(posedge clk) begin
		if (rst)
			tick <= 1'b0;
		else
			tick <= ~tick;
	end

	always_ff @(posedge clk) begin
		if (rst)
			count <= '0;
		else if (wr_count)
			count <= cp0_wdata;
		else if (tick)
			count <= count + 32'd1;
	end

	// parked far from count so no timer fires out of reset
	always_ff @(posedge clk) begin
		if (rst)
			compare <= '1;
		else if (wr_compare)
			compare <= cp0_wdata;
	end

	always_comb begin
		status_r = '0;
		status_r[status_bev_bit] = 1'b1;
		status_r[status_im_lsb +: status_im_w] = status_im;
		status_r[status_exl_bit] = status_exl;
		status_r[status_ie_bit] = status_ie;
	end

	always_comb begin
		cause_r = '0;
		cause_r[cause_bd_bit] = cause_bd;
		cause_r[cause_ti_bit] = cause_ti;
		cause_r[cause_ip_lsb +: cause_ip_w] = cause_ip;
		cause_r[cause_exccode_lsb +: cause_exccode_w] = cause_exccode;
	end

	// mfc0 read, unknown numbers give 0
	always_comb begin
		cp0_rdata = '0;
		if (sel_ok) begin
			case (reg_num)
				badvaddr_num: cp0_rdata = badvaddr;
				count_num:    cp0_rdata = count;
				compare_num:  cp0_rdata = compare;
				status_num:   cp0_rdata = status_r;
				cause_num:    cp0_rdata = cause_r;
				epc_num:      cp0_rdata = epc;
				default:      cp0_rdata = '0;
			endcase
		end
	end

	assign int_pending = !status_exl && status_ie && |(status_im & cause_ip);

endmodule

// ==== design/exc_redirect.sv ====
module exc_redirect #(
	parameter logic [31:0] exc_vector = exc_pkg::exc_vector_default
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        exc_take,
	input  logic        eret_q,
	input  logic [31:0] epc,
	output logic        flush,
	output logic [31:0] redirect_pc
);

	logic        req;
	logic [31:0] target;

	assign req = exc_take || eret_q;

	// exception entry beats return
	always_comb begin
		if (exc_take)
			target = exc_vector;
		else
			target = epc;
	end

	// one cycle flush pulse after the request
	always_ff @(posedge clk) begin
		if (rst)
			flush <= 1'b0;
		else
			flush <= req;
	end

	// epc sampled in the eret cycle
	always_ff @(posedge clk) begin
		if (req)
			redirect_pc <= target;
	end

endmodule

// ==== design/exc_unit.sv ====
module exc_unit #(
	parameter logic [31:0] exc_vector = exc_pkg::exc_vector_default
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        commit_valid,
	input  logic [31:0] commit_pc,
	input  logic        commit_is_slot,
	input  logic        fetch_adel,
	input  logic        ri,
	input  logic        ov,
	input  logic        sys,
	input  logic        bp,
	input  logic        mem_adel,
	input  logic        mem_ades,
	input  logic [31:0] mem_vaddr,
	input  logic [7:0]  cp0_addr,
	input  logic        cp0_wen,
	input  logic [31:0] cp0_wdata,
	input  logic        eret,
	input  logic [5:0]  ext_int,
	output logic [31:0] cp0_rdata,
	output logic        flush,
	output logic [31:0] redirect_pc,
	output logic        int_pending
);
	import exc_pkg::*;

	logic [exc_n-1:0] exc_type;
	logic             exc_take;
	logic [31:0]      bad_vaddr;
	logic             cp0_we_q;
	logic             eret_q;
	logic [31:0]      epc;

	exc_prioritizer prio_i (
		.commit_valid (commit_valid),
		.commit_pc    (commit_pc),
		.fetch_adel   (fetch_adel),
		.ri           (ri),
		.ov           (ov),
		.sys          (sys),
		.bp           (bp),
		.mem_adel     (mem_adel),
		.mem_ades     (mem_ades),
		.mem_vaddr    (mem_vaddr),
		.cp0_wen      (cp0_wen),
		.eret         (eret),
		.int_pending  (int_pending),
		.exc_type     (exc_type),
		.exc_take     (exc_take),
		.bad_vaddr    (bad_vaddr),
		.cp0_we_q     (cp0_we_q),
		.eret_q       (eret_q)
	);

	cp0_regs cp0_i (
		.clk            (clk),
		.rst            (rst),
		.cp0_addr       (cp0_addr),
		.cp0_we_q       (cp0_we_q),
		.cp0_wdata      (cp0_wdata),
		.cp0_rdata      (cp0_rdata),
		.exc_type       (exc_type),
		.commit_pc      (commit_pc),
		.commit_is_slot (commit_is_slot),
		.bad_vaddr      (bad_vaddr),
		.ext_int        (ext_int),
		.eret_q         (eret_q),
		.epc            (epc),
		.int_pending    (int_pending)
	);

	exc_redirect #(
		.exc_vector (exc_vector)
	) redirect_i (
		.clk         (clk),
		.rst         (rst),
		.exc_take    (exc_take),
		.eret_q      (eret_q),
		.epc         (epc),
		.flush       (flush),
		.redirect_pc (redirect_pc)
	);

endmodule

// ==== dv/exc_unit_tb.sv ====
module exc_unit_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import cp0_reg_pkg::*;

	localparam string vector_file = "dv/exc_input.txt";

	logic        clk;
	logic        rst;
	logic        commit_valid;
	logic [31:0] commit_pc;
	logic        commit_is_slot;
	logic        fetch_adel;
	logic        ri;
	logic        ov;
	logic        sys;
	logic        bp;
	logic        mem_adel;
	logic        mem_ades;
	logic [31:0] mem_vaddr;
	logic [7:0]  cp0_addr;
	logic        cp0_wen;
	logic [31:0] cp0_wdata;
	logic        eret;
	logic [5:0]  ext_int;
	logic [31:0] cp0_rdata;
	logic        flush;
	logic [31:0] redirect_pc;
	logic        int_pending;

	string lines[$];
	int    value_errors;
	int    other_errors;
	int    cycles;
	int    limit;

	exc_unit dut_i (
		.clk            (clk),
		.rst            (rst),
		.commit_valid   (commit_valid),
		.commit_pc      (commit_pc),
		.commit_is_slot (commit_is_slot),
		.fetch_adel     (fetch_adel),
		.ri             (ri),
		.ov             (ov),
		.sys            (sys),
		.bp             (bp),
		.mem_adel       (mem_adel),
		.mem_ades       (mem_ades),
		.mem_vaddr      (mem_vaddr),
		.cp0_addr       (cp0_addr),
		.cp0_wen        (cp0_wen),
		.cp0_wdata      (cp0_wdata),
		.eret           (eret),
		.ext_int        (ext_int),
		.cp0_rdata      (cp0_rdata),
		.flush          (flush),
		.redirect_pc    (redirect_pc),
		.int_pending    (int_pending)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// register name for error lines
	function automatic string reg_name(input logic [7:0] addr);
		if (addr[2:0] != 3'd0)
			return "unimplemented";
		case (addr[7:3])
			badvaddr_num: return "badvaddr";
			count_num:    return "count";
			compare_num:  return "compare";
			status_num:   return "status";
			cause_num:    return "cause";
			epc_num:      return "epc";
			default:      return "unimplemented";
		endcase
	endfunction

	task automatic read_vectors();
		int    fd;
		string line;
		fd = $fopen(vector_file, "r");
		if (fd == 0) begin
			other_errors++;
			$display("could not open the vector file %s", vector_file);
		end else begin
			while (!$feof(fd)) begin
				line = "";
				// skip comments and blank lines
				if ($fgets(line, fd) != 0 && line.len() > 1 && line.substr(0, 0) != "#")
					lines.push_back(line);
			end
			$fclose(fd);
		end
	endtask

	// "x" in the file means the field is not checked
	task automatic check_value(input string test, input string field, input string exp_s,
			input logic [31:0] act);
		logic [31:0] exp;
		if (exp_s != "x") begin
			exp = exp_s.atohex();
			if (act !== exp) begin
				value_errors++;
				$display("error %s %s expected %h actual %h", test, field, exp, act);
			end
		end
	endtask

	task automatic run_vector(input string line);
		string name;
		string exp_rdata;
		string exp_flush;
		string exp_pc;
		int    n;
		logic  pend;
		@(negedge clk);
		n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %s %s %s",
			name, commit_valid, commit_pc, commit_is_slot, fetch_adel, ri, ov, sys, bp,
			mem_adel, mem_ades, mem_vaddr, cp0_addr, cp0_wen, cp0_wdata, eret, ext_int,
			exp_rdata, exp_flush, exp_pc);
		if (n != 20) begin
			other_errors++;
			$display("malformed vector line: %s", line);
		end else begin
			// int_pending before the edge decides whether this commit takes an interrupt
			pend = int_pending;
			// sample just before the next falling edge
			@(posedge clk);
			#3;
			check_value(name, $sformatf("cp0_rdata %s", reg_name(cp0_addr)), exp_rdata,
				cp0_rdata);
			check_value(name, "flush", exp_flush, {31'd0, flush});
			check_value(name, "redirect_pc", exp_pc, redirect_pc);
			// a valid commit with no flag and no eret flushes only for an interrupt
			if (commit_valid && !(fetch_adel || ri || ov || sys || bp || mem_adel || mem_ades
					|| eret))
				check_value(name, "int_pending", exp_flush, {31'd0, pend});
		end
	endtask

	initial begin
		rst = 1'b1;
		commit_valid = 1'b0;
		commit_pc = '0;
		commit_is_slot = 1'b0;
		fetch_adel = 1'b0;
		ri = 1'b0;
		ov = 1'b0;
		sys = 1'b0;
		bp = 1'b0;
		mem_adel = 1'b0;
		mem_ades = 1'b0;
		mem_vaddr = '0;
		cp0_addr = '0;
		cp0_wen = 1'b0;
		cp0_wdata = '0;
		eret = 1'b0;
		ext_int = '0;
		value_errors = 0;
		other_errors = 0;
		read_vectors();
		if (lines.size() == 0) begin
			other_errors++;
			$display("no vectors were found in %s", vector_file);
		end
		limit = lines.size() + 20;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		foreach (lines[i])
			run_vector(lines[i]);
		$display("vectors %0d, value errors %0d, other errors %0d",
			lines.size(), value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// watchdog
	initial begin
		cycles = 0;
		wait (limit > 0);
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		other_errors++;
		$display("timeout: the vectors did not finish within %0d cycles", limit);
		$display("vectors %0d, value errors %0d, other errors %0d",
			lines.size(), value_errors, other_errors);
		$display("Something failed");
		$finish;
	end

endmodule

// ==== dv/exc_input.txt ====
# name valid pc slot fetch_adel ri ov sys bp mem_adel mem_ades mem_vaddr cp0_addr cp0_wen cp0_wdata eret ext_int
# then expected cp0_rdata flush redirect_pc, sampled after the line's clock edge, x = not checked
rd_status_rst 0 00000000 0 0 0 0 0 0 0 0 00000000 60 0 00000000 0 00 00400000 0 x
rd_cause_rst 0 00000000 0 0 0 0 0 0 0 0 00000000 68 0 00000000 0 00 00000000 0 x
wr_status 1 00400000 0 0 0 0 0 0 0 0 00000000 60 1 ffffff00 0 00 0040ff00 0 x
wr_epc 1 00400004 0 0 0 0 0 0 0 0 00000000 70 1 12345678 0 00 12345678 0 x
wr_compare 1 00400008 0 0 0 0 0 0 0 0 00000000 58 1 00abcdef 0 00 00abcdef 0 x
wr_cause_sw 1 0040000c 0 0 0 0 0 0 0 0 00000000 68 1 ffffffff 0 00 00000300 0 x
clr_cause_sw 1 00400010 0 0 0 0 0 0 0 0 00000000 68 1 00000000 0 00 00000000 0 x
rd_unimpl 0 00000000 0 0 0 0 0 0 0 0 00000000 78 0 00000000 0 00 00000000 0 x
exc_ri 1 00400100 0 0 1 0 0 0 0 0 00000000 60 0 00000000 0 00 0040ff02 1 bfc00380
eret_ri 1 00400104 0 0 0 0 0 0 0 0 00000000 68 0 00000000 1 00 00000028 1 00400100
exc_ov_slot 1 00400200 1 0 0 1 0 0 0 0 00000000 68 0 00000000 0 00 80000030 1 bfc00380
eret_ov 1 00400204 0 0 0 0 0 0 0 0 00000000 60 0 00000000 1 00 0040ff00 1 004001fc
exc_sys 1 00400400 0 0 0 0 1 0 0 0 00000000 68 0 00000000 0 00 00000020 1 bfc00380
eret_sys 1 00400404 0 0 0 0 0 0 0 0 00000000 70 0 00000000 1 00 00400400 1 00400400
exc_bp_slot 1 00400500 1 0 0 0 0 1 0 0 00000000 70 0 00000000 0 00 004004fc 1 bfc00380
eret_bp 1 00400504 0 0 0 0 0 0 0 0 00000000 68 0 00000000 1 00 80000024 1 004004fc
exc_fetch_adel 1 00400601 0 1 0 0 0 0 0 0 00000000 40 0 00000000 0 00 00400601 1 bfc00380
eret_fetch_adel 1 00400604 0 0 0 0 0 0 0 0 00000000 68 0 00000000 1 00 00000010 1 00400601
exc_mem_adel 1 00400700 0 0 0 0 0 0 1 0 10000003 40 0 00000000 0 00 10000003 1 bfc00380
eret_mem_adel 1 00400704 0 0 0 0 0 0 0 0 00000000 68 0 00000000 1 00 00000010 1 00400700
exc_mem_ades 1 00400800 0 0 0 0 0 0 0 1 10000006 40 0 00000000 0 00 10000006 1 bfc00380
eret_mem_ades 1 00400804 0 0 0 0 0 0 0 0 00000000 68 0 00000000 1 00 00000014 1 00400800
prio_all 1 00400900 0 1 1 1 1 1 1 1 20000000 58 1 00000000 0 00 00abcdef 1 bfc00380
rd_cause_prio 0 00000000 0 0 0 0 0 0 0 0 00000000 68 0 00000000 0 00 00000010 0 x
nested_ov 1 00400a00 0 0 0 1 0 0 0 0 00000000 40 0 00000000 0 00 00400900 1 bfc00380
nested_ri 1 00400b00 0 0 1 1 0 1 0 0 00000000 68 0 00000000 0 00 00000028 1 bfc00380
eret_nested 1 00400b04 0 0 0 0 0 0 0 0 00000000 60 0 00000000 1 00 0040ff00 1 00400900
invalid_ignored 0 00400c00 0 0 1 0 0 0 0 0 00000000 58 1 00000000 1 00 00abcdef 0 x
wr_status_ie 1 00400c04 0 0 0 0 0 0 0 0 00000000 60 1 00000401 0 00 00400401 0 x
ext_int_on 0 00000000 0 0 0 0 0 0 0 0 00000000 68 0 00000000 0 01 00000428 0 x
int_taken 1 00400d00 0 0 0 0 0 0 0 0 00000000 68 0 00000000 0 01 00000400 1 bfc00380
eret_int 1 00400d04 0 0 0 0 0 0 0 0 00000000 60 0 00000000 1 00 00400401 1 00400d00
wr_status_off 1 00400d08 0 0 0 0 0 0 0 0 00000000 60 1 00000000 0 00 00400000 0 x
wr_count 1 00400d0c 0 0 0 0 0 0 0 0 00000000 48 1 10000000 0 00 10000000 0 x
wr_compare_timer 1 00400d10 0 0 0 0 0 0 0 0 00000000 58 1 10000004 0 00 10000004 0 x
timer_wait 0 00000000 0 0 0 0 0 0 0 0 00000000 58 0 00000000 0 00 10000004 0 x
timer_wait 0 00000000 0 0 0 0 0 0 0 0 00000000 58 0 00000000 0 00 10000004 0 x
timer_wait 0 00000000 0 0 0 0 0 0 0 0 00000000 58 0 00000000 0 00 10000004 0 x
timer_wait 0 00000000 0 0 0 0 0 0 0 0 00000000 58 0 00000000 0 00 10000004 0 x
timer_wait 0 00000000 0 0 0 0 0 0 0 0 00000000 58 0 00000000 0 00 10000004 0 x
timer_wait 0 00000000 0 0 0 0 0 0 0 0 00000000 58 0 00000000 0 00 10000004 0 x
timer_wait 0 00000000 0 0 0 0 0 0 0 0 00000000 58 0 00000000 0 00 10000004 0 x
timer_wait 0 00000000 0 0 0 0 0 0 0 0 00000000 58 0 00000000 0 00 10000004 0 x
timer_wait 0 00000000 0 0 0 0 0 0 0 0 00000000 58 0 00000000 0 00 10000004 0 x
timer_wait 0 00000000 0 0 0 0 0 0 0 0 00000000 58 0 00000000 0 00 10000004 0 x
timer_wait 0 00000000 0 0 0 0 0 0 0 0 00000000 58 0 00000000 0 00 10000004 0 x
timer_wait 0 00000000 0 0 0 0 0 0 0 0 00000000 58 0 00000000 0 00 10000004 0 x
rd_timer 0 00000000 0 0 0 0 0 0 0 0 00000000 68 0 00000000 0 00 40008000 0 x
clr_timer 1 00400d14 0 0 0 0 0 0 0 0 00000000 58 1 00000000 0 00 00000000 0 x
rd_timer_clr 0 00000000 0 0 0 0 0 0 0 0 00000000 68 0 00000000 0 00 00000000 0 x

// ==== compile.f ====
design/cp0_reg_pkg.sv
design/exc_pkg.sv
design/exc_prioritizer.sv
design/cp0_regs.sv
design/exc_redirect.sv
design/exc_unit.sv
dv/exc_unit_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps
TOP       = exc_unit_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
PASS_MSG  = Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only when the pass message shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
